// File: bench/tbClockGen.sv
/*
 * Testbench clock, 8 ns period,
 * and active-low reset held for two cycles
 */

module tbClockGen #(
   parameter int periodNs    = 8, // Clock period
   parameter int resetCycles = 2  // Rising edges with reset asserted
) (
   output logic clk,
   output logic arstN
);

   timeunit 1ns;
   timeprecision 1ps;

   // Free-running clock
   initial begin
      clk = 1'b0;
      forever #(periodNs / 2) clk = ~clk;
   end

   // Release reset just after an edge, like the other inputs
   initial begin
      arstN = 1'b0;
      repeat (resetCycles) @(posedge clk);
      #1 arstN = 1'b1;
   end

endmodule

// File: bench/tbWbPeriph.sv
/*
 * Testbench for the Wishbone peripheral subsystem, table-driven bus master,
 * reference model of both registers, latency measurement and checks
 */

module tbWbPeriph
   import wbBusPkg::*;
   import wbLatencyPkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int latWidth   = 6;   // Latency field width given to the DUT
   localparam int maxRows    = 48;  // Table capacity
   localparam int ackTimeout = 100; // Cycles to wait for an ack
   localparam int laneBits   = busDataWidth / busSelWidth;

   // Targets of an address
   localparam int tgtNone = 0;
   localparam int tgtCfg  = 1;
   localparam int tgtDly  = 2;

   // Addresses built from the address map bits
   localparam logic [busAdrWidth-1:0] windowBase = 32'h1 << regionHi;
   localparam logic [busAdrWidth-1:0] cfgAdr     = windowBase | (32'h1 << cfgSelBit);
   localparam logic [busAdrWidth-1:0] dlyAdr     = windowBase | (32'h1 << dlySelBit);
   localparam logic [busAdrWidth-1:0] bothAdr    = cfgAdr | dlyAdr;
   localparam logic [busAdrWidth-1:0] outsideAdr = 32'h1 << cfgSelBit; // Region bits 000

   logic                    clk;
   logic                    arstN;
   logic                    stb;
   logic                    we;
   logic [busAdrWidth-1:0]  adr;
   logic [busSelWidth-1:0]  sel;
   logic [busDataWidth-1:0] wrData;
   logic                    ack;
   logic [busDataWidth-1:0] rdData;

   // Stimulus table, one row per access
   string                   rowName    [maxRows];
   logic                    rowWrite   [maxRows];
   logic [busAdrWidth-1:0]  rowAdr     [maxRows];
   logic [busSelWidth-1:0]  rowSel     [maxRows];
   logic [busDataWidth-1:0] rowWrData  [maxRows];
   logic [busDataWidth-1:0] rowExpData [maxRows];
   int                      rowExpLat  [maxRows]; // Zero means no ack expected
   int                      rowCount   = 0;

   logic [busDataWidth-1:0] cfgModel = '0; // Register contents after reset
   logic [busDataWidth-1:0] dlyModel = '0;
   int                      seed       = 91;

   tbClockGen tbClockGen_i (
      .clk   (clk),
      .arstN (arstN)
   );

   wbPeriphTop #(.latencyWidth(latWidth)) wbPeriphTop_i (
      .CLK_I  (clk),
      .arstN  (arstN),
      .stb    (stb),
      .we     (we),
      .adr    (adr),
      .sel    (sel),
      .wrData (wrData),
      .ack    (ack),
      .rdData (rdData)
   );

   // Bit mask of the selected byte lanes
   function automatic logic [busDataWidth-1:0] laneMask(input logic [busSelWidth-1:0] s);
      logic [busDataWidth-1:0] mask;
      mask = '0;
      for (int i = 0; i < busSelWidth; i++) begin
         if (s[i]) begin
            mask[i*laneBits +: laneBits] = '1;
         end
      end
      return mask;
   endfunction

   // Which slave should answer, config wins when both bits are set
   function automatic int targetOf(input logic [busAdrWidth-1:0] a);
      if (!(a[regionHi] && !a[regionMid] && !a[regionLo])) begin
         return tgtNone; // Outside the window
      end
      if (a[cfgSelBit]) begin
         return tgtCfg;
      end
      if (a[dlySelBit]) begin
         return tgtDly;
      end
      return tgtNone;
   endfunction

   // Append one access and advance the model
   task automatic addRow(
      input string                   name,
      input logic                    isWrite,
      input logic [busAdrWidth-1:0]  a,
      input logic [busSelWidth-1:0]  s,
      input logic [busDataWidth-1:0] d
   );
      int                      target;
      logic [busDataWidth-1:0] mask;
      if (rowCount >= maxRows) begin
         $display("Stimulus table is full, row %s does not fit", name);
         $display("Simulation failed");
         $fatal(1);
      end
      target = targetOf(a);
      mask   = laneMask(s);
      rowName[rowCount]   = name;
      rowWrite[rowCount]  = isWrite;
      rowAdr[rowCount]    = a;
      rowSel[rowCount]    = s;
      rowWrData[rowCount] = d;
      case (target)
         tgtCfg: begin
            rowExpData[rowCount] = cfgModel;
            rowExpLat[rowCount]  = 1; // Always one cycle
            if (isWrite) begin
               cfgModel = (cfgModel & ~mask) | (d & mask);
            end
         end
         tgtDly: begin
            rowExpData[rowCount] = dlyModel;
            // L+1 with L from the current config fields
            if (isWrite) begin
               rowExpLat[rowCount] = int'(cfgModel[wrLatLsb +: latWidth]) + 1;
               dlyModel = (dlyModel & ~mask) | (d & mask);
            end else begin
               rowExpLat[rowCount] = int'(cfgModel[rdLatLsb +: latWidth]) + 1;
            end
         end
         default: begin
            rowExpData[rowCount] = '0;
            rowExpLat[rowCount]  = 0; // Nobody answers
         end
      endcase
      rowCount++;
   endtask

   // Reports the first mismatch and stops
   task automatic compareValue(
      input string                   name,
      input logic [busDataWidth-1:0] expected,
      input logic [busDataWidth-1:0] actual
   );
      if (expected !== actual) begin
         $display("FAIL %s expected 0x%h actual 0x%h", name, expected, actual);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   task automatic buildTable();
      logic [busSelWidth-1:0]  randSel [3];
      logic [busDataWidth-1:0] randData;
      randSel[0] = 4'b1111;
      randSel[1] = 4'b0011;
      randSel[2] = 4'b1100;
      // Reset values, both latencies zero
      addRow("cfgReadReset", 1'b0, cfgAdr, 4'hF, '0);
      addRow("dlyReadReset", 1'b0, dlyAdr, 4'hF, '0);
      // Partial lane writes to config
      addRow("cfgWriteLane0", 1'b1, cfgAdr, 4'b0001, 32'hA5A5_A5A5);
      addRow("cfgReadLane0", 1'b0, cfgAdr, 4'hF, '0);
      addRow("cfgWriteLane2", 1'b1, cfgAdr, 4'b0100, 32'h1122_3344);
      addRow("cfgReadLane2", 1'b0, cfgAdr, 4'hF, '0);
      addRow("cfgWriteLanes31", 1'b1, cfgAdr, 4'b1010, 32'hDEAD_BEEF);
      addRow("cfgReadLanes31", 1'b0, cfgAdr, 4'hF, '0);
      // Write latency 3, read latency 7
      addRow("cfgWriteLat3and7", 1'b1, cfgAdr, 4'b0011, 32'h0000_0703);
      addRow("cfgReadLat3and7", 1'b0, cfgAdr, 4'hF, '0);
      for (int i = 0; i < 3; i++) begin
         randData = $random(seed);
         addRow($sformatf("dlyWriteRandom%0d", i), 1'b1, dlyAdr, randSel[i], randData);
         addRow($sformatf("dlyReadRandom%0d", i), 1'b0, dlyAdr, 4'hF, '0);
      end
      // Both latencies zero
      addRow("cfgWriteLatZero", 1'b1, cfgAdr, 4'b0011, '0);
      addRow("dlyWriteLatZero", 1'b1, dlyAdr, 4'b0101, 32'h0F0F_0F0F);
      addRow("dlyReadLatZero", 1'b0, dlyAdr, 4'hF, '0);
      // All ones in the low bytes, fields saturate at 63
      addRow("cfgWriteLatMax", 1'b1, cfgAdr, 4'b0011, 32'h0000_FFFF);
      addRow("dlyWriteLatMax", 1'b1, dlyAdr, 4'hF, 32'hCAFE_F00D);
      addRow("dlyReadLatMax", 1'b0, dlyAdr, 4'hF, '0);
      // Both select bits, only config answers
      addRow("bothSelRead", 1'b0, bothAdr, 4'hF, '0);
      addRow("bothSelWrite", 1'b1, bothAdr, 4'b1000, 32'h5A00_0000);
      addRow("cfgReadAfterBoth", 1'b0, cfgAdr, 4'hF, '0);
      addRow("dlyReadAfterBoth", 1'b0, dlyAdr, 4'hF, '0);
      // Outside the window, no ack
      addRow("outsideRead", 1'b0, outsideAdr, 4'hF, '0);
      addRow("outsideWrite", 1'b1, outsideAdr, 4'hF, 32'hFFFF_FFFF);
      addRow("cfgReadFinal", 1'b0, cfgAdr, 4'hF, '0);
   endtask

   task automatic waitForReset();
      int cycles;
      cycles = 0;
      while (arstN !== 1'b1 && cycles < 20) begin
         @(posedge clk);
         cycles++;
      end
      if (arstN !== 1'b1) begin
         $display("Reset was never released");
         $display("Simulation failed");
         $fatal(1);
      end
      @(posedge clk);
      #1;
   endtask

   // One bus access, called 1 ns after a rising edge
   task automatic applyRow(input int idx);
      int                      cycles;
      logic                    gotAck;
      logic [busDataWidth-1:0] seenData;
      stb    = 1'b1;
      we     = rowWrite[idx];
      adr    = rowAdr[idx];
      sel    = rowSel[idx];
      wrData = rowWrData[idx];
      cycles   = 0;
      gotAck   = 1'b0;
      seenData = '0;
      while (!gotAck && cycles < ackTimeout) begin
         @(posedge clk);
         #1; // Sample after outputs settle
         cycles++;
         if (ack) begin
            gotAck   = 1'b1;
            seenData = rdData;
         end
      end
      if (!gotAck && rowExpLat[idx] != 0) begin
         $display("Access %s got no acknowledge within %0d cycles", rowName[idx], ackTimeout);
         $display("Simulation failed");
         $fatal(1);
      end
      compareValue($sformatf("%s latency", rowName[idx]), 32'(rowExpLat[idx]),
                   gotAck ? 32'(cycles) : 32'(0));
      if (!rowWrite[idx] && rowExpLat[idx] != 0) begin
         compareValue($sformatf("%s data", rowName[idx]), rowExpData[idx], seenData);
      end
      if (gotAck) begin
         @(posedge clk); // Strobe still high through the ack cycle
         #1;
         compareValue($sformatf("%s ack pulse", rowName[idx]), '0, 32'(ack));
      end
      stb = 1'b0; // Qualifiers stay until the next access
   endtask

   initial begin
      stb    = 1'b0;
      we     = 1'b0;
      adr    = '0;
      sel    = '0;
      wrData = '0;
      buildTable();
      waitForReset();
      for (int i = 0; i < rowCount; i++) begin
         applyRow(i);
         @(posedge clk); // Strobe low for one edge between accesses
         #1;
      end
      $display("Simulation passed");
      $finish;
   end

endmodule

// File: project.f
source/wbBusPkg.sv
source/wbLatencyPkg.sv
source/wbPeriphSelect.sv
source/wbConfigReg.sv
source/wbDelayedReg.sv
source/wbPeriphTop.sv
bench/tbClockGen.sv
bench/tbWbPeriph.sv

// File: runSim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass message

cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing \
   -f project.f \
   --top-module tbWbPeriph \
   -o simWbPeriph &&
{ ./obj_dir/simWbPeriph > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -q "Simulation passed" sim.log &&
echo "run ok" ||
{ echo "run failed"; exit 1; }

// File: source/wbBusPkg.sv
/*
 * Wishbone bus widths, address map bit positions and window tag,
 * plus the byte-lane merge shared by the register slaves
 */

package wbBusPkg;

   localparam int busDataWidth = 32;                         // Data bus
   localparam int busSelWidth  = 4;                          // One select per byte lane
   localparam int busAdrWidth  = 32;                         // Byte address
   localparam int laneWidth    = busDataWidth / busSelWidth; // Bits per lane

   // Peripheral window 0b100xx... in bits 29:27
   localparam int regionHi  = 29;
   localparam int regionMid = 28;
   localparam int regionLo  = 27;
   localparam logic [2:0] regionTag = 3'b100; // {hi, mid, lo} inside the window

   // Slave selects within the window
   localparam int cfgSelBit = 2; // Configuration register
   localparam int dlySelBit = 4; // Delayed register

   // Replace only the lanes whose select is set
   function automatic logic [busDataWidth-1:0] laneMerge(
      input logic [busDataWidth-1:0] oldData,
      input logic [busDataWidth-1:0] newData,
      input logic [busSelWidth-1:0]  sel
   );
      logic [busDataWidth-1:0] merged;
      merged = oldData;
      for (int lane = 0; lane < busSelWidth; lane++) begin
         if (sel[lane]) begin
            merged[lane*laneWidth +: laneWidth] = newData[lane*laneWidth +: laneWidth];
         end
      end
      return merged;
   endfunction

endpackage

// File: source/wbConfigReg.sv
/*
 * Configuration register, byte-writable, one-cycle ack,
 * exports the write and read latency fields
 */

module wbConfigReg
   import wbBusPkg::*;
   import wbLatencyPkg::*;
#(
   parameter int latencyWidth = 6 // Width of each latency field
) (
   input  logic                    CLK_I,
   input  logic                    arstN,
   input  logic                    stb,       // Decoded strobe
   input  logic                    we,
   input  logic [busSelWidth-1:0]  sel,
   input  logic [busDataWidth-1:0] wrData,
   output logic                    ack,
   output logic [busDataWidth-1:0] rdData,
   output logic [latencyWidth-1:0] wrLatency, // To delayed register
   output logic [latencyWidth-1:0] rdLatency
);

   logic [busDataWidth-1:0] cfgReg;
   logic                    accStart; // New access this edge

   // A strobe still high during ack belongs to the same access
   assign accStart = stb & ~ack;

   // Ack, one pulse per access
   always_ff @(posedge CLK_I or negedge arstN) begin
      if (!arstN) begin
         ack <= 1'b0;
      end else begin
         ack <= accStart;
      end
   end

   // Register contents, latencies are zero after reset
   always_ff @(posedge CLK_I or negedge arstN) begin
      if (!arstN) begin
         cfgReg <= '0;
      end else if (accStart && we) begin
         cfgReg <= laneMerge(cfgReg, wrData, sel); // Selected lanes only
      end
   end

   // Read data captured together with the ack
   always_ff @(posedge CLK_I) begin
      if (accStart && !we) begin
         rdData <= cfgReg;
      end
   end

   // Latency fields for the delayed register
   assign wrLatency = cfgReg[wrLatLsb +: latencyWidth];
   assign rdLatency = cfgReg[rdLatLsb +: latencyWidth];

endmodule

// File: source/wbDelayedReg.sv
/*
 * Data register with programmable write and read latency,
 * ack held back by a small countdown FSM
 */

module wbDelayedReg
   import wbBusPkg::*;
   import wbLatencyPkg::*;
#(
   parameter int latencyWidth = 6 // Width of each latency field
) (
   input  logic                    CLK_I,
   input  logic                    arstN,
   input  logic                    stb,       // Decoded strobe
   input  logic                    we,
   input  logic [busSelWidth-1:0]  sel,
   input  logic [busDataWidth-1:0] wrData,
   input  logic [latencyWidth-1:0] wrLatency, // From configuration register
   input  logic [latencyWidth-1:0] rdLatency,
   output logic                    ack,
   output logic [busDataWidth-1:0] rdData
);

   latState_t               state;
   latState_t               nextState;
   logic [latencyWidth-1:0] latCnt;    // Remaining cycles
   logic [latencyWidth-1:0] accLat;    // Latency of the new access
   logic                    isWrite;   // Direction latched at start
   logic [busDataWidth-1:0] dataReg;

   // Latency chosen by direction, taken at the sampling edge
   assign accLat = we ? wrLatency : rdLatency;

   // Next state
   always_comb begin
      nextState = state;
      case (state)
         latIdle: begin
            if (stb) begin
               nextState = (accLat == '0) ? latAck : latCount; // Zero skips counting
            end
         end
         latCount: begin
            if (latCnt == latencyWidth'(1)) begin
               nextState = latAck;
            end
         end
         latAck: begin
            nextState = latIdle; // Single pulse
         end
         default: begin
            nextState = latIdle;
         end
      endcase
   end

   // State, counter and direction
   always_ff @(posedge CLK_I or negedge arstN) begin
      if (!arstN) begin
         state   <= latIdle;
         latCnt  <= '0;
         isWrite <= 1'b0;
      end else begin
         state <= nextState;
         if (state == latIdle && stb) begin
            latCnt  <= accLat; // Later config writes do not touch this access
            isWrite <= we;
         end else if (state == latCount) begin
            latCnt <= latCnt - 1'b1;
         end
      end
   end

   // Byte-lane write at the end of the ack cycle
   always_ff @(posedge CLK_I or negedge arstN) begin
      if (!arstN) begin
         dataReg <= '0;
      end else if (state == latAck && isWrite) begin
         dataReg <= laneMerge(dataReg, wrData, sel);
      end
   end

   assign ack    = (state == latAck);
   assign rdData = dataReg; // Selector passes it only while ack is high

endmodule

// File: source/wbLatencyPkg.sv
/*
 * Latency FSM states of the delayed register and positions
 * of the latency fields inside the configuration register
 */

package wbLatencyPkg;

   // Delayed register access sequence
   typedef enum logic [1:0] {
      latIdle,  // Waiting for a strobe
      latCount, // Counting down the latency
      latAck    // One cycle of ack
   } latState_t;

   // Field positions in the configuration register
   localparam int wrLatLsb = 0; // Write latency, bits 5:0 at default width
   localparam int rdLatLsb = 8; // Read latency, bits 13:8 at default width

endpackage

// File: source/wbPeriphSelect.sv
/*
 * Address decode of the peripheral window into slave strobes,
 * and merge of slave acks and read data toward the master
 */

module wbPeriphSelect
   import wbBusPkg::*;
(
   input  logic                    stb,       // From master
   input  logic [busAdrWidth-1:0]  adr,
   input  logic                    cfgAck,    // Configuration register response
   input  logic [busDataWidth-1:0] cfgRdData,
   input  logic                    dlyAck,    // Delayed register response
   input  logic [busDataWidth-1:0] dlyRdData,
   output logic                    cfgStb,
   output logic                    dlyStb,
   output logic                    ack,       // Back to master
   output logic [busDataWidth-1:0] rdData
);

   logic       inWindow;
   logic [2:0] regionBits;

   // STB qualifies the access, so upper address bits are left undecoded
   assign regionBits = {adr[regionHi], adr[regionMid], adr[regionLo]};
   assign inWindow   = (regionBits == regionTag);

   // Config register wins when both select bits are set
   assign cfgStb = stb & inWindow & adr[cfgSelBit];
   assign dlyStb = stb & inWindow & adr[dlySelBit] & ~adr[cfgSelBit];

   // At most one slave acks at a time
   assign ack = cfgAck | dlyAck;

   // Only the acking slave reaches the read bus
   always_comb begin
      if (cfgAck) begin
         rdData = cfgRdData;
      end else if (dlyAck) begin
         rdData = dlyRdData;
      end else begin
         rdData = '0; // Idle bus reads zero
      end
   end

endmodule

// File: source/wbPeriphTop.sv
/*
 * Peripheral subsystem top, address decoder with the
 * configuration register and the delayed register
 */

module wbPeriphTop
   import wbBusPkg::*;
#(
   parameter int latencyWidth = 6 // Latency field width, up to 8
) (
   input  logic                    CLK_I,
   input  logic                    arstN,
   input  logic                    stb,
   input  logic                    we,
   input  logic [busAdrWidth-1:0]  adr,
   input  logic [busSelWidth-1:0]  sel,
   input  logic [busDataWidth-1:0] wrData,
   output logic                    ack,
   output logic [busDataWidth-1:0] rdData
);

   logic                    cfgStb;
   logic                    cfgAck;
   logic [busDataWidth-1:0] cfgRdData;
   logic                    dlyStb;
   logic                    dlyAck;
   logic [busDataWidth-1:0] dlyRdData;
   logic [latencyWidth-1:0] wrLatency; // Config fields to delayed register
   logic [latencyWidth-1:0] rdLatency;

   wbPeriphSelect wbPeriphSelect_i (
      .stb       (stb),
      .adr       (adr),
      .cfgAck    (cfgAck),
      .cfgRdData (cfgRdData),
      .dlyAck    (dlyAck),
      .dlyRdData (dlyRdData),
      .cfgStb    (cfgStb),
      .dlyStb    (dlyStb),
      .ack       (ack),
      .rdData    (rdData)
   );

   wbConfigReg #(.latencyWidth(latencyWidth)) wbConfigReg_i (
      .CLK_I     (CLK_I),
      .arstN     (arstN),
      .stb       (cfgStb),
      .we        (we),
      .sel       (sel),
      .wrData    (wrData),
      .ack       (cfgAck),
      .rdData    (cfgRdData),
      .wrLatency (wrLatency),
      .rdLatency (rdLatency)
   );

   wbDelayedReg #(.latencyWidth(latencyWidth)) wbDelayedReg_i (
      .CLK_I     (CLK_I),
      .arstN     (arstN),
      .stb       (dlyStb),
      .we        (we),
      .sel       (sel),
      .wrData    (wrData),
      .wrLatency (wrLatency),
      .rdLatency (rdLatency),
      .ack       (dlyAck),
      .rdData    (dlyRdData)
   );

endmodule
